//--- sp_pkg.sv
// ======================================
// series processing shared definitions
// word and series widths, modulus and the
// one-bit mode encoding used by every block
// ======================================
package sp_pkg;

	// ======================================
	// widths
	// ======================================

	// one series word
	localparam int word_w = 9;

	// words per series
	localparam int series_len = 6;

	// index into a series, counts 0..5
	localparam int idx_w = 3;

	// unreduced weighted sum, worst case 4 * 511 = 2044
	localparam int sum_w = 11;

	// ======================================
	// arithmetic
	// ======================================

	// modulus of the output reduction
	localparam logic [sum_w-1:0] modulus = 11'd509;

	// ======================================
	// types and encodings
	// ======================================

	typedef logic [word_w-1:0] word_t;

	// element 0 holds the first word received
	typedef word_t [series_len-1:0] series_t;

	// per-series mode bit
	localparam logic mode_plain = 1'b0;
	localparam logic mode_sort  = 1'b1;

endpackage

//--- series_capture.sv
// ======================================
// series capture
// collects six streamed words and the mode
// bit into one parallel series, then holds a
// busy flag until the output side finishes
// ======================================
`timescale 1ns/1ps

module series_capture import sp_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    in_valid,
	input  word_t   in_data,
	input  logic    in_mode,
	input  logic    series_done,
	output logic    cap_valid,
	output series_t cap_series,
	output logic    cap_mode
);

	// ======================================
	// state
	// ======================================

	logic [idx_w-1:0] word_cnt;
	logic             busy;
	logic             last_word;

	assign last_word = in_valid && (word_cnt == idx_w'(series_len - 1));

	// word counter, mode latch and handshake flags
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			word_cnt  <= '0;
			cap_valid <= 1'b0;
			cap_mode  <= mode_plain;
			busy      <= 1'b0;
		end else begin
			cap_valid <= 1'b0;
			if (in_valid) begin
				// mode only rides on the first word
				if (word_cnt == '0) begin
					cap_mode <= in_mode;
				end
				if (last_word) begin
					word_cnt  <= '0;
					cap_valid <= 1'b1;
				end else begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
			// busy spans from the capture pulse to the last output word
			if (last_word) begin
				busy <= 1'b1;
			end else if (series_done) begin
				busy <= 1'b0;
			end
		end
	end

	// ======================================
	// holding series
	// ======================================

	always_ff @(posedge clk) begin
		if (in_valid) begin
			cap_series[word_cnt] <= in_data;
		end
	end

	// a new series may only start once the previous one has streamed out
	assert property (@(posedge clk) disable iff (!rst_n) busy |-> !in_valid)
		else $error("series_capture: in_valid while previous series still busy");

endmodule

//--- series_sorter.sv
// ======================================
// series sorter
// keeps a raw copy of the captured series and
// sorts a working copy into descending order
// by odd-even transposition in sort mode
// ======================================
`timescale 1ns/1ps

module series_sorter import sp_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    cap_valid,
	input  series_t cap_series,
	input  logic    cap_mode,
	output logic    sort_valid,
	output series_t raw_series,
	output series_t sorted_series,
	output logic    out_mode
);

	// ======================================
	// state
	// ======================================

	logic [idx_w-1:0] pass_cnt;
	logic             sorting;
	logic             last_pass;
	series_t          work_q;
	series_t          pass_next;

	assign last_pass = sorting && (pass_cnt == idx_w'(series_len - 1));

	// pass counter and done pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pass_cnt   <= '0;
			sorting    <= 1'b0;
			sort_valid <= 1'b0;
			out_mode   <= mode_plain;
		end else begin
			sort_valid <= 1'b0;
			if (cap_valid) begin
				out_mode <= cap_mode;
				pass_cnt <= '0;
				sorting  <= (cap_mode == mode_sort);
				// plain mode has nothing to do, report next cycle
				sort_valid <= (cap_mode == mode_plain);
			end else if (last_pass) begin
				pass_cnt   <= '0;
				sorting    <= 1'b0;
				sort_valid <= 1'b1;
			end else if (sorting) begin
				pass_cnt <= pass_cnt + 1'b1;
			end
		end
	end

	// ======================================
	// compare and swap
	// ======================================

	// even passes work on pairs (0,1) (2,3) (4,5), odd passes on (1,2) (3,4)
	always_comb begin
		pass_next = work_q;
		for (int i = 0; i < series_len - 1; i++) begin
			if (i[0] == pass_cnt[0]) begin
				// larger word moves toward index 0
				if (work_q[i] < work_q[i+1]) begin
					pass_next[i]   = work_q[i+1];
					pass_next[i+1] = work_q[i];
				end
			end
		end
	end

	// raw and working copies
	always_ff @(posedge clk) begin
		if (cap_valid) begin
			raw_series <= cap_series;
			work_q     <= cap_series;
		end else if (sorting) begin
			work_q <= pass_next;
		end
	end

	// untouched in plain mode, so it still equals the raw copy
	assign sorted_series = work_q;

	// the capture side must not deliver a new series mid-sort
	assert property (@(posedge clk) disable iff (!rst_n) sorting |-> !cap_valid)
		else $error("series_sorter: cap_valid arrived during a running sort");

endmodule

//--- mod_509_reduce.sv
// ======================================
// modulo 509 reducer
// folds an 11-bit sum into 0..508 by
// subtracting up to four multiples of 509
// ======================================
`timescale 1ns/1ps

module mod_509_reduce import sp_pkg::*; (
	input  logic [sum_w-1:0] sum,
	output word_t            residue
);

	// candidates for one to four subtractions
	logic [sum_w-1:0] sub_1x;
	logic [sum_w-1:0] sub_2x;
	logic [sum_w-1:0] sub_3x;
	logic [sum_w-1:0] sub_4x;

	assign sub_1x = sum - modulus;
	assign sub_2x = sum - (modulus << 1);
	assign sub_3x = sum - (modulus << 1) - modulus;
	assign sub_4x = sum - (modulus << 2);

	// first candidate that lands below the modulus wins
	always_comb begin
		if (sum < modulus) begin
			residue = word_t'(sum);
		end else if (sub_1x < modulus) begin
			residue = word_t'(sub_1x);
		end else if (sub_2x < modulus) begin
			residue = word_t'(sub_2x);
		end else if (sub_3x < modulus) begin
			residue = word_t'(sub_3x);
		end else begin
			// only sums of 2036 and up get here
			residue = word_t'(sub_4x);
		end
	end

endmodule

//--- series_output.sv
// ======================================
// series output
// forms raw plus sorted or four times raw
// per position, reduces it modulo 509 and
// streams six results on out_valid
// ======================================
`timescale 1ns/1ps

module series_output import sp_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    sort_valid,
	input  series_t raw_series,
	input  series_t sorted_series,
	input  logic    out_mode,
	output logic    out_valid,
	output word_t   out_data,
	output logic    series_done
);

	// ======================================
	// state
	// ======================================

	logic [idx_w-1:0] pos;
	logic             active;
	logic             last_pos;
	logic             emit;
	logic             mode_q;
	series_t          raw_q;
	series_t          sorted_q;

	// position 0 is taken straight from the sorter during sort_valid
	word_t            cur_raw;
	word_t            cur_sorted;
	logic             cur_mode;
	logic [sum_w-1:0] cur_sum;
	word_t            cur_residue;

	assign last_pos = active && (pos == idx_w'(series_len - 1));
	assign emit     = sort_valid || active;

	assign cur_raw    = sort_valid ? raw_series[0] : raw_q[pos];
	assign cur_sorted = sort_valid ? sorted_series[0] : sorted_q[pos];
	assign cur_mode   = sort_valid ? out_mode : mode_q;

	// weighted sum before reduction
	assign cur_sum = (cur_mode == mode_sort) ?
		sum_w'(cur_raw) + sum_w'(cur_sorted) :
		{cur_raw, 2'b00};

	mod_509_reduce reduce_i (
		.sum     (cur_sum),
		.residue (cur_residue)
	);

	// ======================================
	// sequencing
	// ======================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos         <= '0;
			active      <= 1'b0;
			mode_q      <= mode_plain;
			out_valid   <= 1'b0;
			out_data    <= '0;
			series_done <= 1'b0;
		end else begin
			out_valid   <= emit;
			out_data    <= emit ? cur_residue : '0;
			series_done <= last_pos;
			if (sort_valid) begin
				mode_q <= out_mode;
				active <= 1'b1;
				pos    <= idx_w'(1);
			end else if (last_pos) begin
				active <= 1'b0;
				pos    <= '0;
			end else if (active) begin
				pos <= pos + 1'b1;
			end
		end
	end

	// latched series, held for the remaining five positions
	always_ff @(posedge clk) begin
		if (sort_valid) begin
			raw_q    <= raw_series;
			sorted_q <= sorted_series;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> sum_w'(out_data) < modulus)
		else $error("series_output: out_data not reduced below 509");

	// a second series must wait until this burst has ended
	assert property (@(posedge clk) disable iff (!rst_n) active |-> !sort_valid)
		else $error("series_output: sort_valid during an output burst");

endmodule

//--- series_proc.sv
// ======================================
// series processing top level
// capture, sort and output stages of the
// six-word series datapath
// ======================================
`timescale 1ns/1ps

module series_proc import sp_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  in_valid,
	input  word_t in_data,
	input  logic  in_mode,
	output logic  out_valid,
	output word_t out_data
);

	// capture to sorter
	logic    cap_valid;
	series_t cap_series;
	logic    cap_mode;

	// sorter to output
	logic    sort_valid;
	series_t raw_series;
	series_t sorted_series;
	logic    out_mode;

	// end of burst, releases the capture side
	logic    series_done;

	series_capture capture_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_data     (in_data),
		.in_mode     (in_mode),
		.series_done (series_done),
		.cap_valid   (cap_valid),
		.cap_series  (cap_series),
		.cap_mode    (cap_mode)
	);

	series_sorter sorter_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.cap_valid     (cap_valid),
		.cap_series    (cap_series),
		.cap_mode      (cap_mode),
		.sort_valid    (sort_valid),
		.raw_series    (raw_series),
		.sorted_series (sorted_series),
		.out_mode      (out_mode)
	);

	series_output output_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.sort_valid    (sort_valid),
		.raw_series    (raw_series),
		.sorted_series (sorted_series),
		.out_mode      (out_mode),
		.out_valid     (out_valid),
		.out_data      (out_data),
		.series_done   (series_done)
	);

endmodule

//--- tb_series_proc.sv
// ======================================
// series processing testbench
// streams file-driven series through the
// DUT and checks each six-word output burst
// ======================================
`timescale 1ns/1ps

module tb_series_proc import sp_pkg::*; ();

	localparam int max_records = 32;
	localparam int name_w      = 8 * 24;
	localparam int max_latency = 16;
	localparam int field_cnt   = 2 * series_len + 1;

	logic  clk;
	logic  rst_n;
	logic  in_valid;
	word_t in_data;
	logic  in_mode;
	logic  out_valid;
	word_t out_data;

	// ======================================
	// test records
	// ======================================

	string rec_name [max_records];
	int    rec_mode [max_records];
	int    rec_in   [max_records][series_len];
	int    rec_exp  [max_records][series_len];
	int    num_records;
	logic  records_loaded;

	series_proc series_proc_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_mode   (in_mode),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	// 40 ns period
	always #20 clk = ~clk;

	task automatic abort_run;
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at %0t", $time);
	endtask

	task automatic check_value(input string test_name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error: %0s %0s: expected %0d, actual %0d",
				test_name, what, expected, actual);
			abort_run();
		end
	endtask

	task automatic fail_plain(input string msg);
		$display("failure: %0s", msg);
		abort_run();
	endtask

	// ======================================
	// data file
	// ======================================

	task automatic load_records;
		int                fd;
		int                code;
		int                field [field_cnt];
		logic [name_w-1:0] tok;
		logic [8*256-1:0]  line;
		logic              at_end;
		fd = $fopen("series_testdata.txt", "r");
		if (fd == 0) begin
			fail_plain("cannot open series_testdata.txt");
		end
		num_records = 0;
		at_end = 1'b0;
		while (!at_end) begin
			tok = '0;
			code = $fscanf(fd, "%s", tok);
			if (code != 1) begin
				at_end = 1'b1;
			end else if (tok[7:0] == "#" && tok[name_w-1:8] == '0) begin
				// skip the rest of a comment line
				code = $fgets(line, fd);
			end else begin
				if (num_records == max_records) begin
					fail_plain("more test records than the testbench can hold");
				end
				for (int k = 0; k < field_cnt; k++) begin
					code = $fscanf(fd, "%d", field[k]);
					if (code != 1) begin
						fail_plain($sformatf("record %0s is incomplete", tok));
					end
				end
				if (field[0] != 0 && field[0] != 1) begin
					fail_plain($sformatf("record %0s has a mode other than 0 or 1", tok));
				end
				rec_name[num_records] = $sformatf("%0s", tok);
				rec_mode[num_records] = field[0];
				for (int k = 0; k < series_len; k++) begin
					rec_in[num_records][k]  = field[k + 1];
					rec_exp[num_records][k] = field[k + 1 + series_len];
				end
				num_records++;
			end
		end
		$fclose(fd);
		if (num_records == 0) begin
			fail_plain("the data file holds no test records");
		end
		records_loaded = 1'b1;
	endtask

	// ======================================
	// one series in, one burst out
	// ======================================

	// entered and left on a falling edge, so series run back to back
	task automatic run_record(input int r);
		int waited;
		for (int i = 0; i < series_len; i++) begin
			if (i > 0) begin
				@(negedge clk);
				check_value(rec_name[r], "out_valid during input", 0, 32'(out_valid));
				check_value(rec_name[r], "out_data during input", 0, 32'(out_data));
			end
			in_valid = 1'b1;
			in_data  = word_t'(rec_in[r][i]);
			// inverted mode on later words must be ignored
			in_mode  = (rec_mode[r] == 1) ^ (i != 0);
		end
		@(negedge clk);
		in_valid = 1'b0;
		in_data  = '0;
		in_mode  = 1'b0;
		// latency differs by mode
		waited = 0;
		while (out_valid !== 1'b1) begin
			check_value(rec_name[r], "out_data before burst", 0, 32'(out_data));
			waited++;
			if (waited > max_latency) begin
				fail_plain($sformatf("%0s: out_valid never rose", rec_name[r]));
			end
			@(negedge clk);
		end
		for (int i = 0; i < series_len; i++) begin
			if (i > 0) begin
				@(negedge clk);
				if (out_valid !== 1'b1) begin
					fail_plain($sformatf("%0s: out_valid dropped inside the burst",
						rec_name[r]));
				end
			end
			check_value(rec_name[r], $sformatf("word %0d", i), rec_exp[r][i],
				32'(out_data));
		end
		@(negedge clk);
		if (out_valid !== 1'b0) begin
			fail_plain($sformatf("%0s: out_valid burst longer than six cycles",
				rec_name[r]));
		end
		check_value(rec_name[r], "out_data after burst", 0, 32'(out_data));
	endtask

	// ======================================
	// main sequence
	// ======================================

	initial begin
		clk            = 1'b0;
		rst_n          = 1'b0;
		in_valid       = 1'b0;
		in_data        = '0;
		in_mode        = 1'b0;
		records_loaded = 1'b0;
		load_records();
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_value("reset", "out_valid", 0, 32'(out_valid));
		check_value("reset", "out_data", 0, 32'(out_data));
		rst_n = 1'b1;
		// idle right after reset
		repeat (2) begin
			@(negedge clk);
			check_value("after_reset", "out_valid", 0, 32'(out_valid));
			check_value("after_reset", "out_data", 0, 32'(out_data));
		end
		for (int r = 0; r < num_records; r++) begin
			run_record(r);
		end
		$display("NO ERRORS");
		$finish;
	end

	// watchdog, scaled by the number of records
	initial begin
		wait (records_loaded === 1'b1);
		repeat (num_records * 40 + 20) @(posedge clk);
		$display("timeout: %0d test records did not complete in time", num_records);
		abort_run();
	end

endmodule

//--- series_testdata.txt
# name mode in0 in1 in2 in3 in4 in5 exp0 exp1 exp2 exp3 exp4 exp5
# mode 0 gives 4*a mod 509, mode 1 gives (a + descending sorted word) mod 509

# plain mode, small and large inputs
plain_small     0   0   1   2   3 100 127    0   4   8  12 400 508
plain_large     0 128 200 300 400 509 511    3 291 182  73   0   8
plain_mid       0 255 256 381 382 480  64    2   6 506   1 393 256

# sort mode, series already descending
sort_desc       1 500 400 300 200 100   0  491 291  91 400 200   0
sort_desc_top   1 511 510 509 508 255 254    4   2   0 507   1 508

# sort mode, ascending and mixed
sort_asc        1   1   2   3   4   5   6    7   7   7   7   7   7
sort_asc_wide   1  10  50 100 200 300 500    1 350 300 300 350   1
sort_mixed_a    1 300  17 450   8 511  99  302 467 241 107  19 107
sort_mixed_b    1  42 399 256   7 311 128  441 201   3 135 353 135

# sort mode, repeated values and zeros
sort_repeat     1   5   9   5   9   5   9   14  18  14  14  10  14
sort_zero       1   0   0   0   0   0   0    0   0   0   0   0   0
sort_zero_mix   1   0 300   0   0 300   0  300  91   0   0 300   0
sort_repeat_big 1 400 400   0 511 511   0  402 402 400 402   2   0

# back to back, alternating modes
btb_plain_a     0 511   0 128   1 509 300    8   0   3   4   0 182
btb_sort_a      1   3   1   4   1   5   9   12   6   8   4   6  10
btb_plain_b     0 100 200 300 400 500  50  400 291 182  73 473 200
btb_sort_b      1 508 508 508 508 508 508  507 507 507 507 507 507

//--- series_proc.f
sp_pkg.sv
series_capture.sv
series_sorter.sv
mod_509_reduce.sv
series_output.sv
series_proc.sv
tb_series_proc.sv

//--- run_sim.sh
#!/bin/sh
# build and run the series_proc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_series_proc \
	-f series_proc.f -o sim_series_proc
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_series_proc)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
